// ==== flist.f ====
verilog/tcb_pkg.sv
verilog/tcb_if.sv
verilog/tcb_dmx.sv
verilog/tcb_mem.sv
verilog/tcb_reg.sv
verilog/tcb_sys.sv
tests/tb_clk.sv
tests/tb_chk.sv
tests/tb_top.sv

// ==== tests/tb_chk.sv ====
`timescale 1ns/10ps

module tb_chk (
  input  logic        sub,
  input  logic        arst_n,
  // dut handshake and response
  input  logic        vld,
  input  logic        rdy,
  input  logic [31:0] rdt,
  input  logic        err,
  input  logic [31:0] gpio,
  // expectation for the request on the bus
  input  logic [31:0] exp_rdt,
  input  logic [31:0] exp_msk,
  input  logic        exp_err,
  input  logic [31:0] exp_gpio,
  output int          errs
);

  // expectation captured on the transfer edge
  logic        pend;
  logic [31:0] cap_rdt;
  logic [31:0] cap_msk;
  logic        cap_err;
  logic [31:0] cap_gpio;
  int          cnt = 0;

  assign errs = cnt;

  ////////////////////////////////////////
  // reset state
  ////////////////////////////////////////

  // flops have settled to reset by the falling edge
  always @(negedge sub) begin
    if (!arst_n) begin
      // nothing may be ready or flagged while in reset
      if (rdy !== 1'b0 || err !== 1'b0 || gpio !== 32'h0) begin
        $display("mismatch at %0t: in reset rdy=%b err=%b gpio=%h, expected all low",
                 $time, rdy, err, gpio);
        cnt++;
      end
    end
  end

  ////////////////////////////////////////
  // response phase
  ////////////////////////////////////////

  always @(posedge sub) begin
    if (!arst_n) begin
      pend <= 1'b0;
    end else begin
      // response trails the transfer by one cycle
      if (pend) begin
        if ((rdt & cap_msk) !== (cap_rdt & cap_msk)) begin
          $display("mismatch at %0t: rdt %h, expected %h under mask %h",
                   $time, rdt, cap_rdt, cap_msk);
          cnt++;
        end
        if (err !== cap_err) begin
          $display("mismatch at %0t: err %b, expected %b", $time, err, cap_err);
          cnt++;
        end
        // gpio pins against the register model
        if (gpio !== cap_gpio) begin
          $display("mismatch at %0t: gpio %h, expected %h", $time, gpio, cap_gpio);
          cnt++;
        end
      end
      pend     <= vld && rdy;
      cap_rdt  <= exp_rdt;
      cap_msk  <= exp_msk;
      cap_err  <= exp_err;
      cap_gpio <= exp_gpio;
    end
  end

endmodule

// ==== tests/tb_clk.sv ====
`timescale 1ns/10ps

module tb_clk (
  output logic sub,
  output logic arst_n
);

  // free running clock, 20 ns period
  initial begin
    sub = 1'b0;
    forever #10 sub = ~sub;
  end

  // reset held for eight rising edges
  // released on a falling edge, away from the flops
  initial begin
    arst_n = 1'b0;
    repeat (8) @(posedge sub);
    @(negedge sub);
    arst_n = 1'b1;
  end

endmodule

// ==== tests/tb_top.sv ====
`timescale 1ns/10ps

module tb_top;

  logic        sub;
  logic        arst_n;
  // request to the dut
  logic        vld;
  logic        wen;
  logic [15:0] adr;
  logic [3:0]  ben;
  logic [31:0] wdt;
  logic [31:0] gpio_in;
  // response from the dut
  logic        rdy;
  logic [31:0] rdt;
  logic        err;
  logic [31:0] gpio;
  // expectation handed to the checker
  logic [31:0] exp_rdt;
  logic [31:0] exp_msk;
  logic        exp_err;
  logic [31:0] exp_gpio;
  int          chk_errs;

  // vector table, eight words per transfer
  logic [31:0] vec [0:255];
  // register and memory models
  logic [31:0] gpio_mdl;
  logic [31:0] scr_mdl;
  logic [31:0] mem_mdl [0:7];
  int          timeouts;
  int          seed;

  tb_clk clk_gen (.sub(sub), .arst_n(arst_n));

  tcb_sys i_dut (
    .sub(sub), .arst_n(arst_n),
    .vld(vld), .wen(wen), .adr(adr), .ben(ben), .wdt(wdt),
    .rdy(rdy), .rdt(rdt), .err(err),
    .gpio_in(gpio_in), .gpio(gpio)
  );

  tb_chk chk (
    .sub(sub), .arst_n(arst_n),
    .vld(vld), .rdy(rdy), .rdt(rdt), .err(err), .gpio(gpio),
    .exp_rdt(exp_rdt), .exp_msk(exp_msk), .exp_err(exp_err), .exp_gpio(exp_gpio),
    .errs(chk_errs)
  );

  // byte lanes of nw replace those of old where b is set
  function automatic logic [31:0] apply_lanes(logic [31:0] old, logic [31:0] nw, logic [3:0] b);
    logic [31:0] m;
    for (int i = 0; i < 4; i++) begin
      m[8*i +: 8] = {8{b[i]}};
    end
    return (old & ~m) | (nw & m);
  endfunction

  // one transfer, held until rdy or timeout
  task automatic issue(input logic w, input logic [15:0] a, input logic [3:0] b,
                       input logic [31:0] d, input logic [31:0] er,
                       input logic [31:0] em, input logic ee);
    int n;
    // register side effects, only writes with a lane set
    if (w && b != 4'h0 && a == 16'h1000) gpio_mdl = apply_lanes(gpio_mdl, d, b);
    if (w && b != 4'h0 && a == 16'h1008) scr_mdl = apply_lanes(scr_mdl, d, b);
    @(negedge sub);
    vld      = 1'b1;
    wen      = w;
    adr      = a;
    ben      = b;
    wdt      = d;
    exp_rdt  = er;
    exp_msk  = em;
    exp_err  = ee;
    exp_gpio = gpio_mdl;
    n = 0;
    @(posedge sub);
    while (!rdy && n < 16) begin
      n++;
      @(posedge sub);
    end
    if (!rdy) begin
      timeouts++;
      $display("timeout: rdy stayed low for 16 cycles, address %h", a);
    end
  endtask

  initial begin
    int          n;
    logic [31:0] d;
    logic [3:0]  b;
    vld      = 1'b0;
    wen      = 1'b0;
    adr      = 16'h0;
    ben      = 4'h0;
    wdt      = 32'h0;
    gpio_in  = 32'h0;
    exp_rdt  = 32'h0;
    exp_msk  = 32'h0;
    exp_err  = 1'b0;
    exp_gpio = 32'h0;
    gpio_mdl = 32'h0;
    scr_mdl  = 'x;
    timeouts = 0;
    seed     = 32'hae8e;
    for (int i = 0; i < 256; i++) begin
      vec[i] = '1;
    end
    $readmemh("tests/tcb_vectors.txt", vec);

    // wait for reset release
    n = 0;
    while (!arst_n && n < 32) begin
      n++;
      @(posedge sub);
    end
    if (!arst_n) begin
      timeouts++;
      $display("timeout: reset was never released");
    end

    ////////////////////////////////////////
    // directed vectors
    ////////////////////////////////////////
    for (int i = 0; i < 32 && vec[8*i] <= 32'h1; i++) begin
      if (vec[8*i+4] !== gpio_in) begin
        // new pin value, idle while the sync settles
        @(negedge sub);
        vld     = 1'b0;
        gpio_in = vec[8*i+4];
        repeat (4) @(posedge sub);
      end
      issue(vec[8*i][0], vec[8*i+1][15:0], vec[8*i+2][3:0], vec[8*i+3],
            vec[8*i+5], vec[8*i+6], vec[8*i+7][0]);
    end

    ////////////////////////////////////////
    // random phase
    ////////////////////////////////////////
    // memory words 128 to 135, untouched by the vectors
    for (int i = 0; i < 8; i++) begin
      d = $random(seed);
      mem_mdl[i] = d;
      issue(1'b1, 16'h0200 + 16'(4 * i), 4'hf, d, 32'h0, 32'h0, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      d = $random(seed);
      b = 4'($random(seed));
      mem_mdl[i] = apply_lanes(mem_mdl[i], d, b);
      issue(1'b1, 16'h0200 + 16'(4 * i), b, d, 32'h0, 32'h0, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      issue(1'b0, 16'h0200 + 16'(4 * i), 4'hf, 32'h0, mem_mdl[i], 32'hffff_ffff, 1'b0);
    end
    // scratch, each write read straight back
    // zero lanes must be refused
    repeat (6) begin
      d = $random(seed);
      b = 4'($random(seed));
      issue(1'b1, 16'h1008, b, d, 32'h0, 32'h0, b == 4'h0);
      issue(1'b0, 16'h1008, 4'hf, 32'h0, scr_mdl, 32'hffff_ffff, 1'b0);
    end

    // let the last response reach the checker
    @(negedge sub);
    vld = 1'b0;
    repeat (2) @(posedge sub);
    $display("errors: %0d (checker %0d, timeouts %0d)",
             chk_errs + timeouts, chk_errs, timeouts);
    if (chk_errs + timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== tests/tcb_vectors.txt ====
// columns: wen adr ben wdt gpio_in exp_rdt rdt_mask exp_err, all hex
// mask zero skips the data compare, a line of all f ends the table
1 0000 f 11223344 00000000 00000000 00000000 0
1 0004 f 55667788 00000000 00000000 00000000 0
1 0000 5 a1b2c3d4 00000000 00000000 00000000 0
1 0004 a 99aabbcc 00000000 00000000 00000000 0
0 0000 f 00000000 00000000 11b233d4 ffffffff 0
0 0004 f 00000000 00000000 9966bb88 ffffffff 0
1 03fc f deadbeef 00000000 00000000 00000000 0
0 03fc f 00000000 00000000 deadbeef ffffffff 0
1 1008 f 01234567 00000000 00000000 00000000 0
1 1008 2 0000ab00 00000000 00000000 00000000 0
0 1008 f 00000000 00000000 0123ab67 ffffffff 0
1 1000 3 0000c3a5 00000000 00000000 00000000 0
1 1000 8 5a000000 00000000 00000000 00000000 0
0 1000 f 00000000 00000000 5a00c3a5 ffffffff 0
0 1004 f 00000000 a5a55a5a a5a55a5a ffffffff 0
0 100c f 00000000 a5a55a5a 7cb00001 ffffffff 0
1 1004 f ffffffff a5a55a5a 00000000 00000000 1
0 1004 f 00000000 a5a55a5a a5a55a5a ffffffff 0
1 100c f 00000000 a5a55a5a 00000000 00000000 1
0 100c f 00000000 a5a55a5a 7cb00001 ffffffff 0
0 2000 f 00000000 a5a55a5a 00000000 00000000 1
1 3000 f 12345678 a5a55a5a 00000000 00000000 1
1 1008 0 ffffffff a5a55a5a 00000000 00000000 1
0 1008 f 00000000 a5a55a5a 0123ab67 ffffffff 0
0 1000 0 00000000 a5a55a5a 00000000 00000000 1
0 0000 f 00000000 a5a55a5a 11b233d4 ffffffff 0
0 100c f 00000000 a5a55a5a 7cb00001 ffffffff 0
0 0004 f 00000000 a5a55a5a 9966bb88 ffffffff 0
0 1000 f 00000000 a5a55a5a 5a00c3a5 ffffffff 0
0 03fc f 00000000 a5a55a5a deadbeef ffffffff 0
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff

// ==== verilog/tcb_dmx.sv ====
`timescale 1ns/10ps

module tcb_dmx (
  // from the manager
  tcb_if.trg bus,
  // to the memory
  tcb_if.man s0,
  // to the register block
  tcb_if.man s1
);
  import tcb_pkg::*;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  logic mem_hit;
  logic reg_hit;
  sel_t sel_req;
  sel_t sel_rsp;

  // compare only the bits above each window
  assign mem_hit = bus.adr[aw-1:mem_lsb] == mem_base[aw-1:mem_lsb];
  assign reg_hit = bus.adr[aw-1:reg_lsb] == reg_base[aw-1:reg_lsb];

  // memory only when it does not clash with the register window
  // unmapped goes to port 1 where the register block flags it
  assign sel_req = (mem_hit && !reg_hit) ? sel_t'(0) : sel_t'(1);

  // select held for the response phase
  always_ff @(posedge bus.sub or negedge bus.arst_n) begin
    if (!bus.arst_n) begin
      sel_rsp <= '0;
    end else if (bus.trn) begin
      sel_rsp <= sel_req;
    end
  end

  ////////////////////////////////////////
  // request path
  ////////////////////////////////////////

  // only the selected port sees vld
  assign s0.vld = bus.vld & (sel_req == sel_t'(0));
  assign s1.vld = bus.vld & (sel_req == sel_t'(1));

  // request payload goes to both ports
  assign s0.wen = bus.wen;
  assign s0.adr = bus.adr;
  assign s0.ben = bus.ben;
  assign s0.wdt = bus.wdt;
  assign s1.wen = bus.wen;
  assign s1.adr = bus.adr;
  assign s1.ben = bus.ben;
  assign s1.wdt = bus.wdt;

  ////////////////////////////////////////
  // response path
  ////////////////////////////////////////

  // indexable copies of the port responses
  dat_t rsp_rdt [pn];
  logic rsp_err [pn];
  logic req_rdy [pn];

  assign rsp_rdt[0] = s0.rdt;
  assign rsp_rdt[1] = s1.rdt;
  assign rsp_err[0] = s0.err;
  assign rsp_err[1] = s1.err;
  assign req_rdy[0] = s0.rdy;
  assign req_rdy[1] = s1.rdy;

  // rdy follows the request and data the registered select
  assign bus.rdy = req_rdy[sel_req];
  assign bus.rdt = rsp_rdt[sel_rsp];
  assign bus.err = rsp_err[sel_rsp];

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // never two error sources in one response
  a_one_err: assert property (
    @(posedge bus.sub) disable iff (!bus.arst_n)
    bus.rsp |-> !(s0.err && s1.err)
  );

endmodule

// ==== verilog/tcb_if.sv ====
`timescale 1ns/10ps

interface tcb_if (
  input logic sub,
  input logic arst_n
);
  import tcb_pkg::*;

  // request, manager side
  logic vld;
  logic wen;
  adr_t adr;
  ben_t ben;
  dat_t wdt;
  // response, target side
  logic rdy;
  dat_t rdt;
  logic err;

  // transfer happens when both handshake signals are high
  logic trn;
  assign trn = vld & rdy;

  // response phase, trails the transfer by dly cycles
  logic [dly-1:0] trn_d;
  logic           rsp;

  always_ff @(posedge sub or negedge arst_n) begin
    if (!arst_n) begin
      trn_d <= '0;
    end else begin
      trn_d <= (trn_d << 1) | dly'(trn);
    end
  end

  assign rsp = trn_d[dly-1];

  modport man (
    input  sub, arst_n, trn, rsp,
    output vld, wen, adr, ben, wdt,
    input  rdy, rdt, err
  );

  modport trg (
    input  sub, arst_n, trn, rsp,
    input  vld, wen, adr, ben, wdt,
    output rdy, rdt, err
  );

endinterface

// ==== verilog/tcb_mem.sv ====
`timescale 1ns/10ps

module tcb_mem (
  tcb_if.trg bus
);
  import tcb_pkg::*;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  // word array, contents undefined after power up
  dat_t mem [mem_words];

  // word index from the address
  logic [mem_aw-1:0] idx;
  assign idx = bus.adr[mem_lsb-1:ob];

  // write side, byte lanes under ben
  always_ff @(posedge bus.sub) begin
    if (bus.trn && bus.wen) begin
      mem[idx] <= ben_merge(mem[idx], bus.wdt, bus.ben);
    end
  end

  // read side, registered
  // data shows up one cycle after the transfer
  always_ff @(posedge bus.sub) begin
    if (bus.trn && !bus.wen) begin
      bus.rdt <= mem[idx];
    end
  end

  ////////////////////////////////////////
  // handshake and status
  ////////////////////////////////////////

  // ready once out of reset, never stalls
  always_ff @(posedge bus.sub or negedge bus.arst_n) begin
    if (!bus.arst_n) begin
      bus.rdy <= 1'b0;
    end else begin
      bus.rdy <= 1'b1;
    end
  end

  // memory never reports an error
  assign bus.err = 1'b0;

  // manager must issue whole word addresses
  a_align: assert property (
    @(posedge bus.sub) disable iff (!bus.arst_n)
    bus.trn |-> (bus.adr[ob-1:0] == '0)
  );

endmodule

// ==== verilog/tcb_pkg.sv ====
package tcb_pkg;

  ////////////////////////////////////////
  // bus widths and timing
  ////////////////////////////////////////

  // address, data and byte enable widths
  localparam int unsigned aw = 16;
  localparam int unsigned dw = 32;
  localparam int unsigned bw = dw / 8;
  // byte offset bits inside a word
  localparam int unsigned ob = $clog2(bw);
  // response delay in cycles
  localparam int unsigned dly = 1;
  // subordinate port count
  localparam int unsigned pn = 2;

  typedef logic [aw-1:0] adr_t;
  typedef logic [dw-1:0] dat_t;
  typedef logic [bw-1:0] ben_t;
  typedef logic [0:0]    sel_t;

  ////////////////////////////////////////
  // address map
  ////////////////////////////////////////

  // memory region, 1 KiB window
  localparam adr_t        mem_base  = 16'h0000;
  localparam int unsigned mem_words = 256;
  localparam int unsigned mem_aw    = $clog2(mem_words);
  localparam int unsigned mem_lsb   = mem_aw + ob;

  // register region, four words
  localparam adr_t reg_base = 16'h1000;
  typedef logic [1:0] reg_idx_t;
  localparam int unsigned reg_lsb = $bits(reg_idx_t) + ob;

  // register indices
  localparam reg_idx_t idx_gpo = 2'd0;
  localparam reg_idx_t idx_gpi = 2'd1;
  localparam reg_idx_t idx_scr = 2'd2;
  localparam reg_idx_t idx_id  = 2'd3;

  // id register content
  localparam dat_t reg_id = 32'h7cb0_0001;

  // byte lane merge for partial writes
  function automatic dat_t ben_merge(dat_t old, dat_t wdt, ben_t ben);
    dat_t res;
    res = old;
    for (int i = 0; i < bw; i++) begin
      if (ben[i]) res[8*i +: 8] = wdt[8*i +: 8];
    end
    return res;
  endfunction

endpackage

// ==== verilog/tcb_reg.sv ====
`timescale 1ns/10ps

module tcb_reg (
  tcb_if.trg             bus,
  input  tcb_pkg::dat_t  gpio_in,
  output tcb_pkg::dat_t  gpio
);
  import tcb_pkg::*;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  reg_idx_t idx;
  logic     hit;
  logic     ro;
  logic     bad;
  logic     wr_ok;

  assign idx = bus.adr[ob +: $bits(reg_idx_t)];
  // inside the register window
  assign hit = bus.adr[aw-1:reg_lsb] == reg_base[aw-1:reg_lsb];
  // gpio input and id are read only
  assign ro  = (idx == idx_gpi) || (idx == idx_id);

  // error on a window miss, on zero byte lanes or on a write to read only
  assign bad   = !hit || (bus.ben == '0) || (bus.wen && ro);
  assign wr_ok = bus.trn && bus.wen && !bad;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  // two flop sync of gpio_in
  dat_t gpi_s1;
  dat_t gpi_s2;
  // scratch word
  dat_t scr;
  // read mux
  dat_t rd_mux;

  always_ff @(posedge bus.sub or negedge bus.arst_n) begin
    if (!bus.arst_n) begin
      bus.rdy <= 1'b0;
      bus.err <= 1'b0;
      gpio    <= '0;
      gpi_s1  <= '0;
      gpi_s2  <= '0;
    end else begin
      bus.rdy <= 1'b1;
      // err only in the cycle after a transfer
      bus.err <= bus.trn && bad;
      gpi_s1  <= gpio_in;
      gpi_s2  <= gpi_s1;
      if (wr_ok && idx == idx_gpo) begin
        gpio <= ben_merge(gpio, bus.wdt, bus.ben);
      end
    end
  end

  // scratch register with bytewise writes
  always_ff @(posedge bus.sub) begin
    if (wr_ok && idx == idx_scr) begin
      scr <= ben_merge(scr, bus.wdt, bus.ben);
    end
  end

  ////////////////////////////////////////
  // read path
  ////////////////////////////////////////

  always_comb begin
    case (idx)
      idx_gpo: rd_mux = gpio;
      idx_gpi: rd_mux = gpi_s2;
      idx_scr: rd_mux = scr;
      default: rd_mux = reg_id;
    endcase
  end

  // registered read data with one cycle of latency
  always_ff @(posedge bus.sub) begin
    if (bus.trn && !bus.wen) begin
      bus.rdt <= rd_mux;
    end
  end

endmodule

// ==== verilog/tcb_sys.sv ====
`timescale 1ns/10ps

module tcb_sys (
  input  logic          sub,
  input  logic          arst_n,
  // manager request
  input  logic          vld,
  input  logic          wen,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::dat_t wdt,
  // manager response
  output logic          rdy,
  output tcb_pkg::dat_t rdt,
  output logic          err,
  // gpio pins
  input  tcb_pkg::dat_t gpio_in,
  output tcb_pkg::dat_t gpio
);

  ////////////////////////////////////////
  // bus instances
  ////////////////////////////////////////

  // manager side
  tcb_if bus_m  (.sub(sub), .arst_n(arst_n));
  // memory side
  tcb_if bus_s0 (.sub(sub), .arst_n(arst_n));
  // register side
  tcb_if bus_s1 (.sub(sub), .arst_n(arst_n));

  // top ports onto the manager bus
  assign bus_m.vld = vld;
  assign bus_m.wen = wen;
  assign bus_m.adr = adr;
  assign bus_m.ben = ben;
  assign bus_m.wdt = wdt;

  assign rdy = bus_m.rdy;
  assign rdt = bus_m.rdt;
  assign err = bus_m.err;

  ////////////////////////////////////////
  // blocks
  ////////////////////////////////////////

  // address decode and response steering
  tcb_dmx dmx (
    .bus (bus_m.trg),
    .s0  (bus_s0.man),
    .s1  (bus_s1.man)
  );

  // port 0
  tcb_mem mem (
    .bus (bus_s0.trg)
  );

  // port 1, also catches unmapped accesses
  tcb_reg regs (
    .bus     (bus_s1.trg),
    .gpio_in (gpio_in),
    .gpio    (gpio)
  );

endmodule
